/* logic/decodePkg.sv */
package decodePkg;

	////////////////////////////////////////////////////////////////////////////
	// Primary opcodes
	////////////////////////////////////////////////////////////////////////////
	localparam logic [5:0] opRType = 6'b000000; // Uses the function field
	localparam logic [5:0] opJ     = 6'b000010;
	localparam logic [5:0] opJal   = 6'b000011;
	localparam logic [5:0] opBeq   = 6'b000100;
	localparam logic [5:0] opBne   = 6'b000101;
	localparam logic [5:0] opAddi  = 6'b001000;
	localparam logic [5:0] opAndi  = 6'b001100;
	localparam logic [5:0] opOri   = 6'b001101;
	localparam logic [5:0] opLui   = 6'b001111;
	localparam logic [5:0] opLb    = 6'b100000;
	localparam logic [5:0] opLh    = 6'b100001;
	localparam logic [5:0] opLw    = 6'b100011;
	localparam logic [5:0] opSb    = 6'b101000;
	localparam logic [5:0] opSh    = 6'b101001;
	localparam logic [5:0] opSw    = 6'b101011;

	// R-type function codes
	localparam logic [5:0] fnJr    = 6'b001000;
	localparam logic [5:0] fnMfhi  = 6'b010000;
	localparam logic [5:0] fnMthi  = 6'b010001;
	localparam logic [5:0] fnMflo  = 6'b010010;
	localparam logic [5:0] fnMtlo  = 6'b010011;
	localparam logic [5:0] fnMult  = 6'b011000;
	localparam logic [5:0] fnMultu = 6'b011001;
	localparam logic [5:0] fnDiv   = 6'b011010;
	localparam logic [5:0] fnDivu  = 6'b011011;
	localparam logic [5:0] fnAdd   = 6'b100000;
	localparam logic [5:0] fnSub   = 6'b100010;
	localparam logic [5:0] fnAnd   = 6'b100100;
	localparam logic [5:0] fnOr    = 6'b100101;
	localparam logic [5:0] fnSlt   = 6'b101010;
	localparam logic [5:0] fnSltu  = 6'b101011;

	// Multiply/divide unit operations
	typedef enum logic [3:0] {
		mduNone  = 4'd0,
		mduMult  = 4'd1,
		mduMultu = 4'd2,
		mduDiv   = 4'd3,
		mduDivu  = 4'd4,
		mduMfhi  = 4'd5,
		mduMflo  = 4'd6,
		mduMthi  = 4'd7,
		mduMtlo  = 4'd8
	} mduOpE;

	////////////////////////////////////////////////////////////////////////////
	// Decoded bundle
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [1:0] regDst;
		logic       regWrite;
		logic       extOp;     // Sign extend when set
		logic [1:0] aluSrc;
		logic [2:0] aluCtrl;
		logic       memWrite;
		logic [1:0] memToReg;
		logic [2:0] npcOp;
		logic [2:0] cmpOp;
		logic [1:0] beOp;      // Store byte enables
		logic [2:0] deOp;      // Load data extension
		logic       start;
		logic       selAluMdu;
		mduOpE      mduOp;
	} ctrlWord;

	typedef struct packed {
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
	} regFields;

	localparam int queueDepth = 4;
	localparam int ptrW       = $clog2(queueDepth);
	localparam int cntW       = $clog2(queueDepth + 1);
	localparam int multCycles = 5;
	localparam int divCycles  = 10;
	localparam int busyW      = $clog2(divCycles + 1);

endpackage

/* logic/decodedIf.sv */
interface decodedIf;

	logic                 valid;
	logic                 ready;
	decodePkg::ctrlWord   ctrl;
	decodePkg::regFields  regs;

	// Producer side
	modport source (
		output valid,
		input  ready,
		output ctrl,
		output regs
	);

	modport sink (
		input  valid,
		output ready,
		input  ctrl,
		input  regs
	);

endinterface

/* logic/ctrlDecoder.sv */
module ctrlDecoder (
	input  logic        clk,
	input  logic        arstN,
	input  logic        instrValid,
	output logic        instrReady,
	input  logic [31:0] instr,
	decodedIf.source    dOut
);

	logic [5:0] op;
	logic [5:0] fn;
	logic rType;
	logic iAdd, iSub, iAnd, iOr, iSlt, iSltu, iJr;
	logic iMult, iMultu, iDiv, iDivu, iMfhi, iMflo, iMthi, iMtlo;
	logic iOri, iAddi, iAndi, iLui, iLw, iLb, iLh, iSw, iSb, iSh;
	logic iBeq, iBne, iJ, iJal;
	decodePkg::ctrlWord  dec;
	decodePkg::regFields fld;
	decodePkg::ctrlWord  ctrlQ;
	decodePkg::regFields regsQ;
	logic validQ;
	logic accept;

	assign op    = instr[31:26];
	assign fn    = instr[5:0];
	assign rType = op == decodePkg::opRType;

	////////////////////////////////////////////////////////////////////////////
	// Instruction recognition
	////////////////////////////////////////////////////////////////////////////
	assign iAdd   = rType && fn == decodePkg::fnAdd;
	assign iSub   = rType && fn == decodePkg::fnSub;
	assign iAnd   = rType && fn == decodePkg::fnAnd;
	assign iOr    = rType && fn == decodePkg::fnOr;
	assign iSlt   = rType && fn == decodePkg::fnSlt;
	assign iSltu  = rType && fn == decodePkg::fnSltu;
	assign iJr    = rType && fn == decodePkg::fnJr;
	assign iMult  = rType && fn == decodePkg::fnMult;
	assign iMultu = rType && fn == decodePkg::fnMultu;
	assign iDiv   = rType && fn == decodePkg::fnDiv;
	assign iDivu  = rType && fn == decodePkg::fnDivu;
	assign iMfhi  = rType && fn == decodePkg::fnMfhi;
	assign iMflo  = rType && fn == decodePkg::fnMflo;
	assign iMthi  = rType && fn == decodePkg::fnMthi;
	assign iMtlo  = rType && fn == decodePkg::fnMtlo;

	assign iOri  = op == decodePkg::opOri;
	assign iAddi = op == decodePkg::opAddi;
	assign iAndi = op == decodePkg::opAndi;
	assign iLui  = op == decodePkg::opLui;
	assign iLw   = op == decodePkg::opLw;
	assign iLb   = op == decodePkg::opLb;
	assign iLh   = op == decodePkg::opLh;
	assign iSw   = op == decodePkg::opSw;
	assign iSb   = op == decodePkg::opSb;
	assign iSh   = op == decodePkg::opSh;
	assign iBeq  = op == decodePkg::opBeq;
	assign iBne  = op == decodePkg::opBne;
	assign iJ    = op == decodePkg::opJ;
	assign iJal  = op == decodePkg::opJal;

	// Unknown words fall through to the default bundle
	always_comb begin
		dec           = '0;
		dec.regDst    = {iJal, iAdd | iSub | iAnd | iOr | iSlt | iSltu | iMfhi | iMflo};
		dec.regWrite  = iAdd | iSub | iOri | iLw | iLui | iJal | iAnd | iOr | iAddi
			| iAndi | iSlt | iSltu | iLb | iLh | iMfhi | iMflo;
		dec.extOp     = iLw | iSw | iAddi | iLb | iLh | iSb | iSh;
		dec.aluSrc    = {1'b0, iOri | iLw | iSw | iLui | iAddi | iAndi | iLb | iLh | iSb | iSh};
		dec.aluCtrl   = {iLui | iSlt | iSltu,
			iOri | iAnd | iOr | iAndi | iSltu,
			iSub | iAnd | iAndi | iSlt};
		dec.memWrite  = iSw | iSb | iSh;
		dec.memToReg  = {iJal, iLw | iLb | iLh};
		dec.npcOp     = {1'b0, iBeq | iJr | iBne, iJal | iJr | iJ};
		dec.cmpOp     = {2'b00, iBne}; // Only bne compares for inequality
		dec.start     = iMult | iMultu | iDiv | iDivu;
		dec.selAluMdu = iMfhi | iMflo;

		if (iSw) dec.beOp = 2'b00;
		else if (iSb) dec.beOp = 2'b10;
		else if (iSh) dec.beOp = 2'b01;
		else dec.beOp = 2'b11;

		if (iLw) dec.deOp = 3'b000;
		else if (iLb) dec.deOp = 3'b010;
		else if (iLh) dec.deOp = 3'b100;
		else dec.deOp = 3'b111;

		if (iMult) dec.mduOp = decodePkg::mduMult;
		else if (iMultu) dec.mduOp = decodePkg::mduMultu;
		else if (iDiv) dec.mduOp = decodePkg::mduDiv;
		else if (iDivu) dec.mduOp = decodePkg::mduDivu;
		else if (iMfhi) dec.mduOp = decodePkg::mduMfhi;
		else if (iMflo) dec.mduOp = decodePkg::mduMflo;
		else if (iMthi) dec.mduOp = decodePkg::mduMthi;
		else if (iMtlo) dec.mduOp = decodePkg::mduMtlo;
		else dec.mduOp = decodePkg::mduNone;
	end

	assign fld = {instr[25:21], instr[20:16], instr[15:11], instr[15:0]};

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////
	assign instrReady = !validQ || dOut.ready; // Empty or draining this cycle
	assign accept     = instrValid && instrReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
		end else if (accept) begin
			validQ <= 1'b1;
		end else if (dOut.ready) begin
			validQ <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ctrlQ <= dec;
			regsQ <= fld;
		end
	end

	assign dOut.valid = validQ;
	assign dOut.ctrl  = ctrlQ;
	assign dOut.regs  = regsQ;

endmodule

/* logic/ctrlQueue.sv */
module ctrlQueue (
	input  logic    clk,
	input  logic    arstN,
	decodedIf.sink   qIn,
	decodedIf.source qOut
);

	decodePkg::ctrlWord  ctrlMem [decodePkg::queueDepth];
	decodePkg::regFields regsMem [decodePkg::queueDepth];
	logic [decodePkg::ptrW-1:0] wrPtr;
	logic [decodePkg::ptrW-1:0] rdPtr;
	logic [decodePkg::cntW-1:0] count;
	logic push;
	logic pop;

	function automatic logic [decodePkg::ptrW-1:0] nextPtr(
		input logic [decodePkg::ptrW-1:0] ptr
	);
		if (ptr == decodePkg::ptrW'(decodePkg::queueDepth - 1)) return '0;
		return ptr + 1'b1;
	endfunction

	assign qOut.valid = count != '0;
	// Full queue still takes a word when the head leaves
	assign qIn.ready  = (count != decodePkg::cntW'(decodePkg::queueDepth)) || qOut.ready;
	assign push       = qIn.valid && qIn.ready;
	assign pop        = qOut.valid && qOut.ready;

	assign qOut.ctrl = ctrlMem[rdPtr];
	assign qOut.regs = regsMem[rdPtr];

	always_ff @(posedge clk) begin
		if (push) begin
			ctrlMem[wrPtr] <= qIn.ctrl;
			regsMem[wrPtr] <= qIn.regs;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= nextPtr(wrPtr);
			if (pop) rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Idle or simultaneous
			endcase
		end
	end

endmodule

/* logic/mduIssue.sv */
module mduIssue (
	input  logic                clk,
	input  logic                arstN,
	decodedIf.sink              iIn,
	output logic                outValid,
	input  logic                outReady,
	output decodePkg::ctrlWord  outCtrl,
	output decodePkg::regFields outRegs,
	output logic                mduBusy
);

	logic [decodePkg::busyW-1:0] busyCnt;
	logic usesUnit;
	logic hold;
	logic issue;
	logic isDiv;

	////////////////////////////////////////////////////////////////////////////
	// Hazard check on the queue head
	////////////////////////////////////////////////////////////////////////////
	assign usesUnit = iIn.ctrl.mduOp != decodePkg::mduNone;
	assign mduBusy  = busyCnt != '0;
	assign hold     = mduBusy && usesUnit; // Unit ops wait for the count

	assign outValid  = iIn.valid && !hold;
	assign iIn.ready = outReady && !hold;
	assign issue     = outValid && outReady;

	assign isDiv = iIn.ctrl.mduOp == decodePkg::mduDiv
		|| iIn.ctrl.mduOp == decodePkg::mduDivu;

	// Head goes out unchanged
	assign outCtrl = iIn.ctrl;
	assign outRegs = iIn.regs;

	// Busy time of the unit
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busyCnt <= '0;
		end else if (issue && iIn.ctrl.start) begin
			busyCnt <= isDiv ? decodePkg::busyW'(decodePkg::divCycles)
				: decodePkg::busyW'(decodePkg::multCycles);
		end else if (mduBusy) begin
			busyCnt <= busyCnt - 1'b1;
		end
	end

endmodule

/* logic/decodeTop.sv */
module decodeTop (
	input  logic        clk,
	input  logic        arstN,
	input  logic        instrValid,
	output logic        instrReady,
	input  logic [31:0] instr,
	output logic        outValid,
	input  logic        outReady,
	output logic [1:0]  regDst,
	output logic        regWrite,
	output logic        extOp,
	output logic [1:0]  aluSrc,
	output logic [2:0]  aluCtrl,
	output logic        memWrite,
	output logic [1:0]  memToReg,
	output logic [2:0]  npcOp,
	output logic [2:0]  cmpOp,
	output logic [1:0]  beOp,
	output logic [2:0]  deOp,
	output logic        start,
	output logic        selAluMdu,
	output logic [3:0]  mduOp,
	output logic [4:0]  rs,
	output logic [4:0]  rt,
	output logic [4:0]  rd,
	output logic [15:0] imm,
	output logic        mduBusy
);

	decodePkg::ctrlWord  outCtrl;
	decodePkg::regFields outRegs;

	decodedIf decIf ();
	decodedIf qIf ();

	ctrlDecoder ctrlDecoder_inst (
		.clk        (clk),
		.arstN      (arstN),
		.instrValid (instrValid),
		.instrReady (instrReady),
		.instr      (instr),
		.dOut       (decIf.source)
	);

	ctrlQueue ctrlQueue_inst (
		.clk   (clk),
		.arstN (arstN),
		.qIn   (decIf.sink),
		.qOut  (qIf.source)
	);

	mduIssue mduIssue_inst (
		.clk      (clk),
		.arstN    (arstN),
		.iIn      (qIf.sink),
		.outValid (outValid),
		.outReady (outReady),
		.outCtrl  (outCtrl),
		.outRegs  (outRegs),
		.mduBusy  (mduBusy)
	);

	// Bundle fields onto plain ports
	assign regDst    = outCtrl.regDst;
	assign regWrite  = outCtrl.regWrite;
	assign extOp     = outCtrl.extOp;
	assign aluSrc    = outCtrl.aluSrc;
	assign aluCtrl   = outCtrl.aluCtrl;
	assign memWrite  = outCtrl.memWrite;
	assign memToReg  = outCtrl.memToReg;
	assign npcOp     = outCtrl.npcOp;
	assign cmpOp     = outCtrl.cmpOp;
	assign beOp      = outCtrl.beOp;
	assign deOp      = outCtrl.deOp;
	assign start     = outCtrl.start;
	assign selAluMdu = outCtrl.selAluMdu;
	assign mduOp     = outCtrl.mduOp;

	assign rs  = outRegs.rs;
	assign rt  = outRegs.rt;
	assign rd  = outRegs.rd;
	assign imm = outRegs.imm;

endmodule

/* tests/decodeTb.sv */
module decodeTb;

	localparam int nItems = 1500;
	localparam logic [31:0] lfsrMask = 32'h80200003;
	localparam int tReset = 0, tDecode = 1, tRegs = 2, tOrder = 3, tHazard = 4, tPass = 5;

	// Function codes in the first half, opcodes in the second, illegal codes at the end of each
	localparam logic [5:0] codeTable [32] = '{
		decodePkg::fnAdd, decodePkg::fnSub, decodePkg::fnAnd, decodePkg::fnOr,
		decodePkg::fnSlt, decodePkg::fnSltu, decodePkg::fnJr, decodePkg::fnMult,
		decodePkg::fnMultu, decodePkg::fnDiv, decodePkg::fnDivu, decodePkg::fnMfhi,
		decodePkg::fnMflo, decodePkg::fnMthi, decodePkg::fnMtlo, 6'b111111,
		decodePkg::opOri, decodePkg::opAddi, decodePkg::opAndi, decodePkg::opLui,
		decodePkg::opLw, decodePkg::opLb, decodePkg::opLh, decodePkg::opSw,
		decodePkg::opSb, decodePkg::opSh, decodePkg::opBeq, decodePkg::opBne,
		decodePkg::opJ, decodePkg::opJal, 6'b111111, 6'b010000
	};

	logic clk, arstN, instrValid, instrReady, outValid, outReady, mduBusy;
	logic [31:0] instr;
	logic [1:0] regDst, aluSrc, memToReg, beOp;
	logic [2:0] aluCtrl, npcOp, cmpOp, deOp;
	logic regWrite, extOp, memWrite, start, selAluMdu;
	logic [3:0] mduOp;
	logic [4:0] rs, rt, rd;
	logic [15:0] imm;

	logic [31:0] lfsr = 32'h19e8;
	decodePkg::ctrlWord expCtrlQ [$];
	decodePkg::regFields expRegsQ [$];
	decodePkg::ctrlWord expC;
	decodePkg::regFields expR;
	string testName [6] = '{"reset", "decode", "regFields", "order", "hazard", "passBusy"};
	int errCount [6];
	int checkCount [6];
	int inCount, outCount, edgeNo, startGap, passBusy, readyLowSeen, stallLeft, waitCycles;
	int lastStartEdge = -1;
	logic running = 1'b0;
	logic draining = 1'b0;
	logic timedOut = 1'b0;

	// All ports share their names with the DUT
	decodeTop decodeTop_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ lfsrMask : lfsr >> 1; // Galois step
		end
		return r;
	endfunction

	function automatic logic [31:0] makeWord();
		logic [4:0] idx;
		logic [31:0] rnd;
		idx = 5'(randBits(5));
		rnd = randBits(26);
		if (idx < 5'd16) return {6'b0, rnd[25:6], codeTable[idx]};
		return {codeTable[idx], rnd[25:0]};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic decodePkg::ctrlWord modelCtrl(input logic [31:0] word);
		logic [28:0] c;
		// regDst regWr ext aluSrc aluCtrl memWr memToReg npc cmp be de start sel mduOp
		c = 29'b00_0_0_00_000_0_00_000_000_11_111_0_0_0000;
		if (word[31:26] == decodePkg::opRType) begin
			case (word[5:0])
				decodePkg::fnAdd:   c = 29'b01_1_0_00_000_0_00_000_000_11_111_0_0_0000;
				decodePkg::fnSub:   c = 29'b01_1_0_00_001_0_00_000_000_11_111_0_0_0000;
				decodePkg::fnAnd:   c = 29'b01_1_0_00_011_0_00_000_000_11_111_0_0_0000;
				decodePkg::fnOr:    c = 29'b01_1_0_00_010_0_00_000_000_11_111_0_0_0000;
				decodePkg::fnSlt:   c = 29'b01_1_0_00_101_0_00_000_000_11_111_0_0_0000;
				decodePkg::fnSltu:  c = 29'b01_1_0_00_110_0_00_000_000_11_111_0_0_0000;
				decodePkg::fnJr:    c = 29'b00_0_0_00_000_0_00_011_000_11_111_0_0_0000;
				decodePkg::fnMult:  c = 29'b00_0_0_00_000_0_00_000_000_11_111_1_0_0001;
				decodePkg::fnMultu: c = 29'b00_0_0_00_000_0_00_000_000_11_111_1_0_0010;
				decodePkg::fnDiv:   c = 29'b00_0_0_00_000_0_00_000_000_11_111_1_0_0011;
				decodePkg::fnDivu:  c = 29'b00_0_0_00_000_0_00_000_000_11_111_1_0_0100;
				decodePkg::fnMfhi:  c = 29'b01_1_0_00_000_0_00_000_000_11_111_0_1_0101;
				decodePkg::fnMflo:  c = 29'b01_1_0_00_000_0_00_000_000_11_111_0_1_0110;
				decodePkg::fnMthi:  c = 29'b00_0_0_00_000_0_00_000_000_11_111_0_0_0111;
				decodePkg::fnMtlo:  c = 29'b00_0_0_00_000_0_00_000_000_11_111_0_0_1000;
				default: ;
			endcase
		end else begin
			case (word[31:26])
				decodePkg::opOri:  c = 29'b00_1_0_01_010_0_00_000_000_11_111_0_0_0000;
				decodePkg::opAddi: c = 29'b00_1_1_01_000_0_00_000_000_11_111_0_0_0000;
				decodePkg::opAndi: c = 29'b00_1_0_01_011_0_00_000_000_11_111_0_0_0000;
				decodePkg::opLui:  c = 29'b00_1_0_01_100_0_00_000_000_11_111_0_0_0000;
				decodePkg::opLw:   c = 29'b00_1_1_01_000_0_01_000_000_11_000_0_0_0000;
				decodePkg::opLb:   c = 29'b00_1_1_01_000_0_01_000_000_11_010_0_0_0000;
				decodePkg::opLh:   c = 29'b00_1_1_01_000_0_01_000_000_11_100_0_0_0000;
				decodePkg::opSw:   c = 29'b00_0_1_01_000_1_00_000_000_00_111_0_0_0000;
				decodePkg::opSb:   c = 29'b00_0_1_01_000_1_00_000_000_10_111_0_0_0000;
				decodePkg::opSh:   c = 29'b00_0_1_01_000_1_00_000_000_01_111_0_0_0000;
				decodePkg::opBeq:  c = 29'b00_0_0_00_000_0_00_010_000_11_111_0_0_0000;
				decodePkg::opBne:  c = 29'b00_0_0_00_000_0_00_010_001_11_111_0_0_0000;
				decodePkg::opJ:    c = 29'b00_0_0_00_000_0_00_001_000_11_111_0_0_0000;
				decodePkg::opJal:  c = 29'b10_1_0_00_000_0_10_001_000_11_111_0_0_0000;
				default: ;
			endcase
		end
		return decodePkg::ctrlWord'(c);
	endfunction

	function automatic decodePkg::regFields modelRegs(input logic [31:0] word);
		return {word[25:21], word[20:16], word[15:11], word[15:0]};
	endfunction

	task automatic checkValue(input int id, input string what, input logic [31:0] expVal,
		input logic [31:0] actVal);
		checkCount[id]++;
		assert (actVal == expVal) else begin
			errCount[id]++;
			$display("** Error %s: %s expected 'h%0h actual 'h%0h", testName[id], what,
				expVal, actVal);
		end
	endtask

	task automatic reportTest(input int id);
		$display("Test %-9s %0d checks, %0d errors", testName[id], checkCount[id], errCount[id]);
	endtask

	// One output transfer against the scoreboard head
	task automatic handleOutput();
		outCount++;
		assert (expCtrlQ.size() != 0) begin
			expC = expCtrlQ.pop_front();
			expR = expRegsQ.pop_front();
			checkValue(tDecode, "ctrl", {3'b0, expC}, {3'b0, regDst, regWrite, extOp, aluSrc,
				aluCtrl, memWrite, memToReg, npcOp, cmpOp, beOp, deOp, start, selAluMdu, mduOp});
			checkValue(tRegs, "rs rt rd imm", {1'b0, expR}, {1'b0, rs, rt, rd, imm});
			if (expC.mduOp != decodePkg::mduNone) begin
				checkValue(tHazard, "mduBusy at unit issue", 32'd0, {31'd0, mduBusy});
				if (lastStartEdge >= 0) begin
					checkCount[tHazard]++;
					assert (edgeNo - lastStartEdge >= startGap + 1) else begin
						errCount[tHazard]++;
						$display("Test hazard: unit op left %0d edges after a start, %0d needed",
							edgeNo - lastStartEdge, startGap + 1);
					end
				end
			end else if (mduBusy && startGap == decodePkg::divCycles) begin
				passBusy++;
			end
			if (expC.start) begin
				lastStartEdge = edgeNo;
				startGap = (expC.mduOp == decodePkg::mduDiv || expC.mduOp == decodePkg::mduDivu)
					? decodePkg::divCycles : decodePkg::multCycles;
			end
		end else begin
			errCount[tOrder]++;
			$display("Test order: output transfer with no pending instruction");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Monitor and stimulus on the values from before the edge
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (running) begin
			edgeNo++;
			if (!instrReady) readyLowSeen++;
			if (instrValid && instrReady) begin
				expCtrlQ.push_back(modelCtrl(instr));
				expRegsQ.push_back(modelRegs(instr));
				inCount++;
			end
			if (outValid && outReady) handleOutput();

			if (!instrValid || instrReady) begin // Held word stays until taken
				if (!draining && inCount < nItems && randBits(2) != 0) begin
					instr <= makeWord();
					instrValid <= 1'b1;
				end else begin
					instrValid <= 1'b0;
				end
			end
			if (draining) begin
				outReady <= 1'b1;
			end else if (stallLeft > 0) begin
				outReady <= 1'b0;
				stallLeft--;
			end else if (randBits(6) == 0) begin
				stallLeft = 30 + int'(randBits(5)); // Long back-pressure span
				outReady <= 1'b0;
			end else begin
				outReady <= randBits(2) != 0;
			end
		end
	end

	initial begin
		int i;
		int totalErr;
		int totalChk;
		arstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		outReady = 1'b0;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkValue(tReset, "instrReady", 32'd1, {31'd0, instrReady});
		checkValue(tReset, "outValid", 32'd0, {31'd0, outValid});
		checkValue(tReset, "mduBusy", 32'd0, {31'd0, mduBusy});
		reportTest(tReset);
		running = 1'b1;

		waitCycles = 0;
		while (inCount < nItems && waitCycles < 50000) begin
			@(posedge clk);
			waitCycles++;
		end
		if (inCount < nItems) begin
			timedOut = 1'b1;
			$display("Timeout: only %0d of %0d instructions were accepted", inCount, nItems);
		end
		draining = 1'b1;
		waitCycles = 0;
		while (expCtrlQ.size() != 0 && waitCycles < 2000) begin
			@(posedge clk);
			waitCycles++;
		end
		if (expCtrlQ.size() != 0) begin
			timedOut = 1'b1;
			$display("Timeout: %0d decoded instructions never left the DUT", expCtrlQ.size());
		end
		repeat (5) @(posedge clk); // Idle tail catches extra outputs

		checkValue(tOrder, "output count", inCount, outCount);
		checkValue(tOrder, "outValid after drain", 32'd0, {31'd0, outValid});
		checkCount[tOrder]++;
		assert (readyLowSeen > 0) else begin
			errCount[tOrder]++;
			$display("Test order: instrReady never dropped under back-pressure");
		end
		checkCount[tPass]++;
		assert (passBusy > 0) else begin
			errCount[tPass]++;
			$display("Test passBusy: no plain instruction left while a divide was running");
		end

		totalErr = 0;
		totalChk = 0;
		for (i = 0; i < 6; i++) begin
			if (i != tReset) reportTest(i);
			totalErr += errCount[i];
			totalChk += checkCount[i];
		end
		$display("Tests 6, checks %0d, errors %0d, timeouts %0d", totalChk, totalErr, timedOut);
		if (totalErr == 0 && !timedOut) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* sim.f */
logic/decodePkg.sv
logic/decodedIf.sv
logic/ctrlDecoder.sv
logic/ctrlQueue.sv
logic/mduIssue.sv
logic/decodeTop.sv
tests/decodeTb.sv

/* Makefile */
TOP = decodeTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o simv
	out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
